/* hw/sysbus_pkg.sv */
// Shared bus types, region encoding, I/O port map and memory map for the system bus controller
package sysbus_pkg;

    // ========================================================================
    // Bus types
    // ========================================================================

    typedef logic [19:0] cpu_addr_t;
    typedef logic [15:0] cpu_data_t;
    typedef logic [24:0] sdr_addr_t;

    // Where a CPU memory cycle lands in SDRAM
    typedef enum logic [1:0] {
        region_rom  = 2'd0,
        region_bank = 2'd1,
        region_ram  = 2'd2,
        region_none = 2'd3
    } region_t;

    // ========================================================================
    // I/O ports (word addresses)
    // ========================================================================

    // Read side
    localparam logic [7:0] io_port_inputs_p12  = 8'h00;
    localparam logic [7:0] io_port_flags       = 8'h02;
    localparam logic [7:0] io_port_dip         = 8'h04;
    localparam logic [7:0] io_port_inputs_p34  = 8'h06;

    // Write side
    localparam logic [7:0] io_port_sysflags    = 8'h02;
    localparam logic [7:0] io_port_bank        = 8'h20;
    localparam logic [7:0] io_port_sound_reset = 8'hc0;

    // ========================================================================
    // Memory map
    // ========================================================================

    localparam cpu_addr_t bank_window_start = 20'hA0000;
    localparam cpu_addr_t ram_window_start  = 20'hE0000;
    localparam cpu_addr_t ram_window_end    = 20'hEFFFF;
    localparam cpu_addr_t bank_size         = 20'h20000;
    localparam sdr_addr_t bank_rom_offset   = 25'h100000;

endpackage

/* hw/bus_cycle_if.sv */
// Decoded CPU bus cycle, passed from the decode stage to the execute and result stages
`timescale 1ns/100ps

interface bus_cycle_if;
    import sysbus_pkg::*;

    // Cycle kind
    logic      io_wr;
    logic      io_rd;
    logic      mem_wr;
    logic      mem_rd;
    logic      int_ack;
    logic      mem_start;

    // Address and payload
    cpu_addr_t word_addr;
    cpu_data_t wdata;
    logic [1:0] byte_sel;

    // Memory map result
    region_t   region;
    logic      writable;
    sdr_addr_t sdr_addr;

    modport decode (
        output io_wr, io_rd, mem_wr, mem_rd, int_ack, mem_start,
        output word_addr, wdata, byte_sel, region, writable, sdr_addr
    );

    modport execute (
        input io_wr, mem_wr, mem_start,
        input word_addr, wdata, byte_sel, region, writable, sdr_addr
    );

    modport result (
        input io_rd, mem_rd, int_ack, word_addr, region
    );

endinterface

/* hw/bus_cycle_decode.sv */
// Decode stage turning V33 status pins and address into cycle kind, region and SDRAM address
`timescale 1ns/100ps

module bus_cycle_decode #(
    parameter sysbus_pkg::sdr_addr_t rom_base = 25'h0,
    parameter sysbus_pkg::sdr_addr_t ram_base = 25'h1F00000
) (
    input  logic                  clk_sys,
    input  logic                  reset_n,

    input  logic                  m_io,
    input  logic                  r_w,
    input  logic                  busst0,
    input  logic                  busst1,
    input  logic                  n_dstb,
    input  logic                  n_bcyst,
    input  logic                  n_ube,
    input  sysbus_pkg::cpu_addr_t addr,
    input  sysbus_pkg::cpu_data_t dout,

    input  logic [3:0]            bank_select,

    bus_cycle_if.decode           bus
);
    import sysbus_pkg::*;

    localparam cpu_addr_t bank_window_end = bank_window_start + bank_size;

    logic      mem_cycle;
    logic      n_bcyst_d;
    cpu_addr_t word_addr;
    region_t   region;
    logic      writable;
    sdr_addr_t sdr_addr;

    // ========================================================================
    // Cycle kind from the status pins
    // ========================================================================

    assign bus.io_wr   = ~m_io & ~r_w & ~busst1 &  busst0 & ~n_dstb;
    assign bus.io_rd   = ~m_io &  r_w & ~busst1 &  busst0;
    assign bus.mem_wr  =  m_io & ~r_w & ~busst1 &  busst0 & ~n_dstb;
    assign bus.mem_rd  =  m_io &  r_w & ~busst1;
    assign bus.int_ack = ~m_io &  r_w & ~busst1 & ~busst0 & ~n_dstb;

    assign mem_cycle = bus.mem_rd | bus.mem_wr;

    // Outside a memory cycle the delayed strobe is forced high,
    // so only a fresh falling edge of n_bcyst starts a request
    always_ff @(posedge clk_sys or negedge reset_n) begin
        if (!reset_n) begin
            n_bcyst_d <= 1'b1;
        end else begin
            n_bcyst_d <= ~mem_cycle | n_bcyst;
        end
    end

    assign bus.mem_start = mem_cycle & ~n_bcyst & n_bcyst_d;

    // ========================================================================
    // Address translation
    // ========================================================================

    assign word_addr = {addr[19:1], 1'b0};

    always_comb begin
        region   = region_none;
        writable = 1'b0;
        sdr_addr = '0;
        if (word_addr < bank_window_start) begin
            region   = region_rom;
            sdr_addr = rom_base + sdr_addr_t'(word_addr);
        end else if (word_addr < bank_window_end) begin
            // Selected bank sits after the fixed ROM image
            region   = region_bank;
            sdr_addr = rom_base + bank_rom_offset
                     + sdr_addr_t'(bank_select) * sdr_addr_t'(bank_size)
                     + sdr_addr_t'(word_addr - bank_window_start);
        end else if (word_addr >= ram_window_start && word_addr <= ram_window_end) begin
            region   = region_ram;
            writable = 1'b1;
            sdr_addr = ram_base + sdr_addr_t'(word_addr[15:0]);
        end
    end

    assign bus.word_addr = word_addr;
    assign bus.wdata     = dout;
    assign bus.byte_sel  = {~n_ube, ~addr[0]};
    assign bus.region    = region;
    assign bus.writable  = writable;
    assign bus.sdr_addr  = sdr_addr;

    // CPU holds the address for the clock after a memory cycle starts
    a_addr_held: assert property (@(posedge clk_sys) disable iff (!reset_n)
        bus.mem_start |=> $stable(addr));

endmodule

/* hw/io_registers.sv */
// Execute stage for I/O writes to the system flags, ROM bank select and sound reset registers
`timescale 1ns/100ps

module io_registers (
    input  logic        clk_sys,
    input  logic        reset_n,

    bus_cycle_if.execute bus,

    output logic [7:0]  sys_flags,
    output logic [3:0]  bank_select,
    output logic        sound_reset
);
    import sysbus_pkg::*;

    logic wr_sysflags;
    logic wr_bank;
    logic wr_sound_reset;

    // ========================================================================
    // Port decode
    // ========================================================================

    // Full address compare with the upper I/O address bits clear
    assign wr_sysflags    = bus.io_wr && (bus.word_addr == cpu_addr_t'(io_port_sysflags));
    assign wr_bank        = bus.io_wr && (bus.word_addr == cpu_addr_t'(io_port_bank));
    assign wr_sound_reset = bus.io_wr && (bus.word_addr == cpu_addr_t'(io_port_sound_reset));

    // ========================================================================
    // Registers
    // ========================================================================

    // Bits 1:0 drive the coin counters and bit 2 is the soft screen flip
    always_ff @(posedge clk_sys or negedge reset_n) begin
        if (!reset_n) begin
            sys_flags <= 8'h00;
        end else if (wr_sysflags) begin
            sys_flags <= bus.wdata[7:0];
        end
    end

    always_ff @(posedge clk_sys or negedge reset_n) begin
        if (!reset_n) begin
            bank_select <= 4'h0;
        end else if (wr_bank) begin
            bank_select <= bus.wdata[3:0];
        end
    end

    // Sound CPU is held in reset while bit 0 is low
    always_ff @(posedge clk_sys or negedge reset_n) begin
        if (!reset_n) begin
            sound_reset <= 1'b0;
        end else if (wr_sound_reset) begin
            sound_reset <= ~bus.wdata[0];
        end
    end

    // Write data holds while the CPU keeps the I/O write strobe low
    a_wdata_held: assert property (@(posedge clk_sys) disable iff (!reset_n)
        bus.io_wr && $past(bus.io_wr) |-> $stable(bus.wdata));

endmodule

/* hw/sdram_request.sv */
// Memory cycle stage driving the SDRAM request toggle, write select and read data capture
`timescale 1ns/100ps

module sdram_request (
    input  logic                  clk_sys,
    input  logic                  reset_n,

    bus_cycle_if.execute          bus,

    // SDRAM CPU channel
    output sysbus_pkg::sdr_addr_t sdr_cpu_addr,
    output sysbus_pkg::cpu_data_t sdr_cpu_din,
    output logic                  sdr_cpu_req,
    output logic [1:0]            sdr_cpu_wr_sel,
    input  sysbus_pkg::cpu_data_t sdr_cpu_dout,
    input  logic                  sdr_cpu_ack,

    // Toward the CPU
    output sysbus_pkg::cpu_data_t mem_data,
    output logic                  mem_ready
);
    import sysbus_pkg::*;

    logic busy;
    logic start_req;
    logic req_done;

    // ========================================================================
    // Handshake
    // ========================================================================

    // Starts seen while busy are dropped since the CPU is already held
    assign start_req = ~busy & bus.mem_start & (bus.region != region_none);

    // Request is complete once the SDRAM mirrors the toggle
    assign req_done  = busy & (sdr_cpu_req == sdr_cpu_ack);

    always_ff @(posedge clk_sys or negedge reset_n) begin
        if (!reset_n) begin
            busy        <= 1'b0;
            sdr_cpu_req <= 1'b0;
        end else if (start_req) begin
            busy        <= 1'b1;
            sdr_cpu_req <= ~sdr_cpu_req;
        end else if (req_done) begin
            busy        <= 1'b0;
        end
    end

    assign mem_ready = ~busy;

    // ========================================================================
    // Request payload and read data
    // ========================================================================

    always_ff @(posedge clk_sys) begin
        if (start_req) begin
            sdr_cpu_addr <= bus.sdr_addr;
            sdr_cpu_din  <= bus.wdata;
            // ROM writes still go out with no byte enabled
            if (bus.mem_wr && bus.writable) begin
                sdr_cpu_wr_sel <= bus.byte_sel;
            end else begin
                sdr_cpu_wr_sel <= 2'b00;
            end
        end
        if (req_done) begin
            mem_data <= sdr_cpu_dout;
        end
    end

    // SDRAM acknowledges only a request that is pending
    a_ack_only_pending: assert property (@(posedge clk_sys) disable iff (!reset_n)
        !busy |-> sdr_cpu_ack == sdr_cpu_req);

endmodule

/* hw/read_data_mux.sv */
// Result stage: builds player switch bytes and selects the word returned to the CPU
`timescale 1ns/100ps

module read_data_mux (
    bus_cycle_if.result           bus,

    input  logic                  kick_harness,
    input  logic [3:0]            coin,
    input  logic [3:0]            start_buttons,
    input  logic [9:0]            p1_input,
    input  logic [9:0]            p2_input,
    input  logic [9:0]            p3_input,
    input  logic [9:0]            p4_input,
    input  logic [23:0]           dip_sw,
    input  logic [7:0]            int_vector,
    input  sysbus_pkg::cpu_data_t mem_data,

    output sysbus_pkg::cpu_data_t din
);
    import sysbus_pkg::*;

    logic [7:0] switches_p1;
    logic [7:0] switches_p2;
    logic [7:0] switches_p3;
    logic [7:0] switches_p4;
    cpu_data_t  flags;

    // Common layout of a player byte, bits 5 and 4 vary by player and harness
    function automatic logic [7:0] player_byte(input logic [9:0] p, input logic b5,
                                               input logic b4);
        player_byte = {p[4], p[5], b5, b4, p[3], p[2], p[1], p[0]};
    endfunction

    // ========================================================================
    // Player switches
    // ========================================================================

    // Kick harness puts the kick button on bit 5
    assign switches_p1 = player_byte(p1_input, kick_harness & p1_input[6], 1'b0);
    assign switches_p2 = player_byte(p2_input, kick_harness & p2_input[6], 1'b0);

    // Harness borrows port 06 for the extra buttons of players 1 and 2
    assign switches_p3 = kick_harness ? 8'h00
                                      : player_byte(p3_input, coin[2], start_buttons[2]);
    assign switches_p4 = kick_harness ? {p2_input[9], p2_input[8], p2_input[7], 1'b0,
                                         p1_input[9], p1_input[8], p1_input[7], 1'b0}
                                      : player_byte(p4_input, coin[3], start_buttons[3]);

    // DMA busy, test and R bits read back as inactive
    assign flags = {~dip_sw[23:16], 4'b1111, ~coin[1:0], ~start_buttons[1:0]};

    // ========================================================================
    // Read word select
    // ========================================================================

    always_comb begin
        if (bus.int_ack) begin
            din = {8'h00, int_vector};
        end else if (bus.mem_rd) begin
            din = (bus.region == region_none) ? 16'hffff : mem_data;
        end else if (bus.io_rd) begin
            case (bus.word_addr[7:0])
                io_port_inputs_p12: din = {~switches_p2, ~switches_p1};
                io_port_flags:      din = flags;
                io_port_dip:        din = ~dip_sw[15:0];
                io_port_inputs_p34: din = {~switches_p4, ~switches_p3};
                default:            din = 16'hffff;
            endcase
        end else begin
            din = 16'hffff;
        end
    end

endmodule

/* hw/m92_sysbus_top.sv */
// Top level of the CPU system bus controller; connect V33 bus pins, board inputs and SDRAM
`timescale 1ns/100ps

module m92_sysbus_top #(
    parameter sysbus_pkg::sdr_addr_t rom_base = 25'h0,
    parameter sysbus_pkg::sdr_addr_t ram_base = 25'h1F00000
) (
    input  logic                  clk_sys,
    input  logic                  reset_n,

    // CPU bus
    input  logic                  m_io,
    input  logic                  r_w,
    input  logic                  busst0,
    input  logic                  busst1,
    input  logic                  n_dstb,
    input  logic                  n_bcyst,
    input  logic                  n_ube,
    input  sysbus_pkg::cpu_addr_t addr,
    input  sysbus_pkg::cpu_data_t dout,
    input  logic [7:0]            int_vector,
    output sysbus_pkg::cpu_data_t din,
    output logic                  mem_ready,

    // Board and player inputs
    input  logic                  kick_harness,
    input  logic [3:0]            coin,
    input  logic [3:0]            start_buttons,
    input  logic [9:0]            p1_input,
    input  logic [9:0]            p2_input,
    input  logic [9:0]            p3_input,
    input  logic [9:0]            p4_input,
    input  logic [23:0]           dip_sw,

    // SDRAM CPU channel
    output sysbus_pkg::sdr_addr_t sdr_cpu_addr,
    output sysbus_pkg::cpu_data_t sdr_cpu_din,
    output logic                  sdr_cpu_req,
    output logic [1:0]            sdr_cpu_wr_sel,
    input  sysbus_pkg::cpu_data_t sdr_cpu_dout,
    input  logic                  sdr_cpu_ack,

    // Control outputs
    output logic [1:0]            coin_counter,
    output logic                  flipped,
    output logic [3:0]            bank_select,
    output logic                  sound_reset
);
    import sysbus_pkg::*;

    logic [7:0] sys_flags;
    cpu_data_t  mem_data;

    bus_cycle_if bus ();

    bus_cycle_decode #(
        .rom_base (rom_base),
        .ram_base (ram_base)
    ) u_decode (
        .clk_sys     (clk_sys),
        .reset_n     (reset_n),
        .m_io        (m_io),
        .r_w         (r_w),
        .busst0      (busst0),
        .busst1      (busst1),
        .n_dstb      (n_dstb),
        .n_bcyst     (n_bcyst),
        .n_ube       (n_ube),
        .addr        (addr),
        .dout        (dout),
        .bank_select (bank_select),
        .bus         (bus.decode)
    );

    io_registers u_io_registers (
        .clk_sys     (clk_sys),
        .reset_n     (reset_n),
        .bus         (bus.execute),
        .sys_flags   (sys_flags),
        .bank_select (bank_select),
        .sound_reset (sound_reset)
    );

    sdram_request u_sdram_request (
        .clk_sys        (clk_sys),
        .reset_n        (reset_n),
        .bus            (bus.execute),
        .sdr_cpu_addr   (sdr_cpu_addr),
        .sdr_cpu_din    (sdr_cpu_din),
        .sdr_cpu_req    (sdr_cpu_req),
        .sdr_cpu_wr_sel (sdr_cpu_wr_sel),
        .sdr_cpu_dout   (sdr_cpu_dout),
        .sdr_cpu_ack    (sdr_cpu_ack),
        .mem_data       (mem_data),
        .mem_ready      (mem_ready)
    );

    read_data_mux u_read_data_mux (
        .bus           (bus.result),
        .kick_harness  (kick_harness),
        .coin          (coin),
        .start_buttons (start_buttons),
        .p1_input      (p1_input),
        .p2_input      (p2_input),
        .p3_input      (p3_input),
        .p4_input      (p4_input),
        .dip_sw        (dip_sw),
        .int_vector    (int_vector),
        .mem_data      (mem_data),
        .din           (din)
    );

    assign coin_counter = sys_flags[1:0];

    // Soft flip combined with the cabinet flip DIP
    assign flipped = ~sys_flags[2] ^ ~dip_sw[8];

endmodule

/* include/sysbus_bus_tasks.svh */
// CPU bus cycle tasks, SDRAM responder and result check, included by the system bus testbench
`ifndef SYSBUS_BUS_TASKS_SVH
`define SYSBUS_BUS_TASKS_SVH

// ============================================================================
// CPU bus cycles
// ============================================================================

// Pin order is m_io, r_w, busst1, busst0, n_dstb
task automatic drive_status(input logic [4:0] pins);
    {m_io, r_w, busst1, busst0, n_dstb} = pins;
endtask

task automatic set_bus_idle();
    drive_status(5'b01111);
    n_bcyst = 1'b1;
    n_ube   = 1'b1;
endtask

// Passive status for one clock between cycles
task automatic idle_bus_cycle();
    set_bus_idle();
    @(posedge clk_sys);
    #1;
endtask

// I/O read or write; write data is taken on the first edge
task automatic io_cycle(input logic write, input cpu_addr_t port, input cpu_data_t data,
                        output cpu_data_t rdata);
    drive_status({1'b0, ~write, 2'b01, 1'b0});
    addr = port;
    dout = data;
    @(posedge clk_sys);
    #1;
    rdata = din;
    idle_bus_cycle();
endtask

task automatic int_ack_cycle(input logic [7:0] vector, output cpu_data_t rdata);
    int_vector = vector;
    drive_status(5'b01000);
    @(posedge clk_sys);
    #1;
    rdata = din;
    idle_bus_cycle();
endtask

// n_bcyst pulses low for one clock, then the CPU waits for mem_ready
task automatic mem_cycle(input logic write, input cpu_addr_t address, input cpu_data_t data,
                         input logic upper_n, output cpu_data_t rdata);
    int waited;
    drive_status({1'b1, ~write, 3'b010});
    n_ube   = upper_n;
    addr    = address;
    dout    = data;
    n_bcyst = 1'b0;
    @(posedge clk_sys);
    #1;
    n_bcyst = 1'b1;
    waited  = 0;
    while (!mem_ready && waited < 64) begin
        @(posedge clk_sys);
        #1;
        waited++;
    end
    if (!mem_ready) begin
        $display("timeout: mem_ready stayed low for 64 cycles at address %h", address);
        timed_out = 1'b1;
        error_count++;
    end
    rdata = din;
    idle_bus_cycle();
endtask

// ============================================================================
// SDRAM responder
// ============================================================================

// Unwritten words read back as a pattern of their address
function automatic cpu_data_t stored_word(input sdr_addr_t key);
    if (sdram_model.exists(key)) begin
        stored_word = sdram_model[key];
    end else begin
        stored_word = key[15:0] ^ 16'h5a5a;
    end
endfunction

// Serves one pending request after a random delay
task automatic service_sdram();
    int unsigned delay;
    sdr_addr_t   key;
    cpu_data_t   word;
    #1;
    if (reset_n && (sdr_cpu_req != sdr_cpu_ack)) begin
        req_count++;
        delay         = 1 + ($urandom % 6);
        key           = sdr_cpu_addr;
        last_sdr_addr = key;
        word          = stored_word(key);
        if (sdr_cpu_wr_sel[1]) begin
            word[15:8] = sdr_cpu_din[15:8];
        end
        if (sdr_cpu_wr_sel[0]) begin
            word[7:0] = sdr_cpu_din[7:0];
        end
        if (sdr_cpu_wr_sel != 2'b00) begin
            sdram_model[key] = word;
        end
        repeat (delay) @(posedge clk_sys);
        #1;
        sdr_cpu_dout = word;
        sdr_cpu_ack  = sdr_cpu_req;
    end
endtask

// ============================================================================
// Results
// ============================================================================

// Nibbles: mem_ready, sound_reset, bank_select, {0, flipped, coin_counter}
function automatic logic [15:0] status_word();
    status_word = {3'b000, mem_ready, 3'b000, sound_reset, bank_select,
                   1'b0, flipped, coin_counter};
endfunction

task automatic check_value(input logic [8*24-1:0] test_name, input logic [31:0] expected,
                           input logic [31:0] actual);
    if (actual !== expected) begin
        $display("mismatch %0s expected %h actual %h", test_name, expected, actual);
        error_count++;
    end
endtask

`endif

/* dv/tb_sysbus.sv */
// Testbench for the system bus controller; runs every step listed in the stimulus file
`timescale 1ns/100ps

module tb_sysbus;
    import sysbus_pkg::*;

    logic        clk_sys = 1'b0;
    logic        reset_n;
    logic        m_io;
    logic        r_w;
    logic        busst0;
    logic        busst1;
    logic        n_dstb;
    logic        n_bcyst;
    logic        n_ube;
    cpu_addr_t   addr;
    cpu_data_t   dout;
    logic [7:0]  int_vector;
    cpu_data_t   din;
    logic        mem_ready;
    logic        kick_harness;
    logic [3:0]  coin;
    logic [3:0]  start_buttons;
    logic [9:0]  p1_input;
    logic [9:0]  p2_input;
    logic [9:0]  p3_input;
    logic [9:0]  p4_input;
    logic [23:0] dip_sw;
    sdr_addr_t   sdr_cpu_addr;
    cpu_data_t   sdr_cpu_din;
    logic        sdr_cpu_req;
    logic [1:0]  sdr_cpu_wr_sel;
    cpu_data_t   sdr_cpu_dout = 16'h0000;
    logic        sdr_cpu_ack = 1'b0;
    logic [1:0]  coin_counter;
    logic        flipped;
    logic [3:0]  bank_select;
    logic        sound_reset;

    // Scoreboard and SDRAM model state
    int          error_count = 0;
    int          test_count = 0;
    int          req_count = 0;
    logic        timed_out = 1'b0;
    sdr_addr_t   last_sdr_addr = '0;
    cpu_data_t   sdram_model [sdr_addr_t];

    m92_sysbus_top UUT (.*);

    always #4 clk_sys = ~clk_sys;

    `include "sysbus_bus_tasks.svh"

    always @(posedge clk_sys) begin
        service_sdram();
    end

    // ========================================================================
    // One step of the stimulus file
    // ========================================================================

    task automatic run_step(input logic [8*24-1:0] test_name, input logic [8*8-1:0] op,
                            input logic [31:0] stim_addr, input logic [31:0] stim_data,
                            input logic [31:0] expected);
        cpu_data_t rdata;
        int        req_before;
        req_before = req_count;
        case (op)
            "stat": begin
                @(posedge clk_sys);
                #1;
                check_value(test_name, expected, {16'h0, status_word()});
            end
            "iow": begin
                io_cycle(1'b1, stim_addr[19:0], stim_data[15:0], rdata);
                check_value(test_name, expected, {16'h0, status_word()});
            end
            "ior": begin
                io_cycle(1'b0, stim_addr[19:0], 16'h0000, rdata);
                check_value(test_name, expected, {16'h0, rdata});
                // I/O never reaches the SDRAM
                check_value(test_name, 32'd0, req_count - req_before);
            end
            "inta": begin
                int_ack_cycle(stim_data[7:0], rdata);
                check_value(test_name, expected, {16'h0, rdata});
            end
            "mrd", "mrdn": begin
                mem_cycle(1'b0, stim_addr[19:0], 16'h0000, 1'b0, rdata);
                check_value(test_name, expected, {16'h0, rdata});
                if (op == "mrdn") begin
                    check_value(test_name, 32'd0, req_count - req_before);
                end
            end
            "mrda": begin
                mem_cycle(1'b0, stim_addr[19:0], 16'h0000, 1'b0, rdata);
                check_value(test_name, expected, {7'h0, last_sdr_addr});
            end
            "mwr", "mwrb": begin
                // Byte writes use the upper lane at odd addresses
                mem_cycle(1'b1, stim_addr[19:0], stim_data[15:0],
                          (op == "mwrb") ? ~stim_addr[0] : 1'b0, rdata);
                check_value(test_name, expected, {16'h0, status_word()});
            end
            default: begin
                $display("unknown operation in the stimulus file for test %0s", test_name);
                error_count++;
            end
        endcase
    endtask

    // ========================================================================
    // Main sequence
    // ========================================================================

    initial begin
        logic [8*128-1:0] line;
        logic [8*24-1:0]  test_name;
        logic [8*8-1:0]   op;
        logic [31:0]      stim_addr;
        logic [31:0]      stim_data;
        logic [31:0]      stim_kick;
        logic [31:0]      expected;
        int               fields;
        int               fd;
        int               errors_before;

        void'($urandom(14554));
        reset_n       = 1'b0;
        set_bus_idle();
        addr          = '0;
        dout          = '0;
        int_vector    = 8'h00;
        kick_harness  = 1'b0;
        coin          = 4'b1010;
        start_buttons = 4'b0110;
        p1_input      = 10'h369;
        p2_input      = 10'h1d6;
        p3_input      = 10'h0c3;
        p4_input      = 10'h23c;
        dip_sw        = 24'h5ac396;
        repeat (4) @(posedge clk_sys);
        #1;
        reset_n = 1'b1;

        fd = $fopen("dv/sysbus_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file dv/sysbus_stimulus.txt");
            error_count++;
        end else begin
            while (!timed_out && $fgets(line, fd) != 0) begin
                fields = $sscanf(line, "%s %s %h %h %h %h", test_name, op, stim_addr,
                                 stim_data, stim_kick, expected);
                // Comment lines open with a lone #
                if (fields == 6 && test_name != "#") begin
                    test_count++;
                    errors_before = error_count;
                    kick_harness  = stim_kick[0];
                    run_step(test_name, op, stim_addr, stim_data, expected);
                    if (error_count == errors_before) begin
                        $display("test %0s ok", test_name);
                    end else begin
                        $display("test %0s FAIL", test_name);
                    end
                end
            end
            $fclose(fd);
        end

        $display("tests run %0d, errors %0d", test_count, error_count);
        if (error_count == 0 && test_count > 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+include
hw/sysbus_pkg.sv
hw/bus_cycle_if.sv
hw/bus_cycle_decode.sv
hw/io_registers.sv
hw/sdram_request.sv
hw/read_data_mux.sv
hw/m92_sysbus_top.sv
dv/tb_sysbus.sv

/* run_sim.sh */
#!/bin/sh
# Build the system bus testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -Iinclude --top-module tb_sysbus \
    -f filelist.f -o sim_sysbus &&
./obj_dir/sim_sysbus | tee /dev/stderr | grep -x "All checks passed" > /dev/null &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

/* dv/sysbus_stimulus.txt */
# name op addr data kick expected, all but name and op in hex
# stat/iow/mwr/mwrb expect the status word, mrda the SDRAM address, others the read data
reset_state      stat  00000  0000  0  1004
rd_p12           ior   00000  0000  0  79b6
rd_flags         ior   00002  0000  0  a5f5
rd_dip           ior   00004  0000  0  3c69
rd_p34           ior   00006  0000  0  13ec
rd_p12_kick      ior   00000  0000  1  5996
rd_p34_kick      ior   00006  0000  1  93ff
rd_unknown_port  ior   00008  0000  0  ffff
wr_flags_a       iow   00002  0005  0  1001
wr_flags_b       iow   00002  0002  0  1006
wr_bank_3        iow   00020  0003  0  1036
wr_snd_hold      iow   000c0  0000  0  1136
wr_snd_run       iow   000c0  0001  0  1036
rd_rom           mrd   01234  0000  0  486e
rd_bank_3        mrd   a2468  0000  0  7e32
rd_bank_3_addr   mrda  a2468  0000  0  162468
wr_bank_a        iow   00020  000a  0  10a6
rd_bank_a_addr   mrda  bfffe  0000  0  25fffe
wr_ram_word      mwr   e1000  beef  0  10a6
wr_ram_hi        mwrb  e1001  3400  0  10a6
rd_ram_merged    mrd   e1000  0000  0  34ef
rd_ram_addr      mrda  e1000  0000  0  1f01000
wr_ram_lo        mwrb  e2000  0077  0  10a6
rd_ram_lo        mrd   e2000  0000  0  7a77
wr_rom           mwr   01234  dead  0  10a6
rd_rom_kept      mrd   01234  0000  0  486e
int_ack          inta  00000  005c  0  005c
rd_unmapped      mrdn  d0000  0000  0  ffff
